// ==== source/riscv_defs.svh ====
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// ---------------------------------------------------------------------
// Data path sizing
// ---------------------------------------------------------------------

// Integer register width, RV32
`define XLEN 32

// Register index width, 32 architectural registers
`define NB_REGS 5

`endif

// ==== source/riscv_pkg.sv ====
`include "riscv_defs.svh"

package riscv_pkg;

  // ---------------------------------------------------------------------
  // One-hot unit select
  // ---------------------------------------------------------------------
  localparam int ALU     = 0;
  localparam int SFT     = 1;
  localparam int BU      = 2;
  localparam int LSU     = 3;
  localparam int NB_UNIT = 4;

  // ---------------------------------------------------------------------
  // One-hot operation vector
  // ---------------------------------------------------------------------
  // ALU
  localparam int ADD  = 0;
  localparam int SUB  = 1;
  localparam int AND  = 2;
  localparam int OR   = 3;
  localparam int XOR  = 4;
  localparam int SLT  = 5;
  localparam int SLTU = 6;
  // Shifter
  localparam int SLL  = 7;
  localparam int SRL  = 8;
  localparam int SRA  = 9;
  // Branch unit
  localparam int BEQ  = 10;
  localparam int BNE  = 11;
  localparam int BLT  = 12;
  localparam int BGE  = 13;
  localparam int JAL  = 14;
  localparam int JALR = 15;
  // Load-store unit
  localparam int LD   = 16;
  localparam int ST   = 17;
  localparam int NB_OPERATION = 18;

  // One-hot access size
  localparam int SZ_B = 0;
  localparam int SZ_H = 1;
  localparam int SZ_W = 2;

  // ---------------------------------------------------------------------
  // Stage interfaces
  // ---------------------------------------------------------------------
  // Operands carry one extra top bit, sign or zero qualified by decode
  typedef struct packed {
    logic [`XLEN-1:0]        pc;
    logic                    rd_v;
    logic [`NB_REGS-1:0]     rd_adr;
    logic [`XLEN:0]          rs1_data;
    logic [`XLEN:0]          rs2_data;
    logic [`XLEN-1:0]        immediat;
    logic [2:0]              access_size;
    logic                    unsign_extension;
    logic [NB_UNIT-1:0]      unit;
    logic [NB_OPERATION-1:0] operation;
  } dec_exe_t;

  typedef struct packed {
    logic             adr_v;
    logic [`XLEN-1:0] adr;
    logic             is_store;
    logic [`XLEN-1:0] store_data;
    logic [2:0]       access_size;
  } mem_req_t;

  // Shared by forwarding and writeback
  typedef struct packed {
    logic                v;
    logic [`NB_REGS-1:0] adr;
    logic [`XLEN-1:0]    data;
  } wbk_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic             branch_instr;
    logic             feedback;
    logic             success;
    logic             failed;
  } pred_fb_t;

endpackage

// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module alu import riscv_pkg::*; (
  input  logic [`XLEN:0]           rs1_data_i,
  input  logic [`XLEN:0]           rs2_data_i,
  input  logic                     alu_en_i,
  input  logic [NB_OPERATION-1:0]  cmd_i,
  output logic [`XLEN-1:0]         data_o
);

  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] diff;
  logic             less;
  logic [`XLEN-1:0] res;

  assign sum  = rs1_data_i[`XLEN-1:0] + rs2_data_i[`XLEN-1:0];
  assign diff = rs1_data_i[`XLEN-1:0] - rs2_data_i[`XLEN-1:0];

  // Extended operands, so one signed compare covers slt and sltu
  assign less = $signed(rs1_data_i) < $signed(rs2_data_i);

  // ---------------------------------------------------------------------
  // Operation select
  // ---------------------------------------------------------------------
  always_comb begin
    res = '0;
    if (cmd_i[ADD]) begin
      res = sum;
    end else if (cmd_i[SUB]) begin
      res = diff;
    end else if (cmd_i[AND]) begin
      res = rs1_data_i[`XLEN-1:0] & rs2_data_i[`XLEN-1:0];
    end else if (cmd_i[OR]) begin
      res = rs1_data_i[`XLEN-1:0] | rs2_data_i[`XLEN-1:0];
    end else if (cmd_i[XOR]) begin
      res = rs1_data_i[`XLEN-1:0] ^ rs2_data_i[`XLEN-1:0];
    end else if (cmd_i[SLT] | cmd_i[SLTU]) begin
      res = {{(`XLEN-1){1'b0}}, less};
    end
  end

  assign data_o = alu_en_i ? res : '0;

endmodule

// ==== source/shifter.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module shifter import riscv_pkg::*; (
  input  logic [`XLEN-1:0]         rs1_data_i,
  input  logic [`XLEN-1:0]         rs2_data_i,
  input  logic                     shifter_en_i,
  input  logic [NB_OPERATION-1:0]  cmd_i,
  output logic [`XLEN-1:0]         data_o
);

  logic [$clog2(`XLEN)-1:0] shamt;
  logic [`XLEN-1:0]         res;

  // Only the low bits of rs2 count
  assign shamt = rs2_data_i[$clog2(`XLEN)-1:0];

  always_comb begin
    res = '0;
    if (cmd_i[SLL]) begin
      res = rs1_data_i << shamt;
    end else if (cmd_i[SRL]) begin
      res = rs1_data_i >> shamt;
    end else if (cmd_i[SRA]) begin
      res = $signed(rs1_data_i) >>> shamt;
    end
  end

  assign data_o = shifter_en_i ? res : '0;

endmodule

// ==== source/bu.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module bu import riscv_pkg::*; (
  input  logic [`XLEN:0]           rs1_data_i,
  input  logic [`XLEN:0]           rs2_data_i,
  input  logic [`XLEN-1:0]         immediat_i,
  input  logic [`XLEN-1:0]         pc_data_i,
  input  logic                     bu_en_i,
  input  logic [NB_OPERATION-1:0]  cmd_i,
  input  logic                     pred_v_i,
  input  logic                     pred_is_taken_i,
  output logic                     branch_v_o,
  output logic [`XLEN-1:0]         pc_nxt_o,
  output logic [`XLEN-1:0]         data_o,
  output logic                     pred_feedback_o,
  output logic                     pred_success_o,
  output logic                     pred_failed_o
);

  logic             equal;
  logic             less;
  logic             jump;
  logic             taken;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] jalr_sum;
  logic [`XLEN-1:0] target;
  logic             pred_ok;

  // ---------------------------------------------------------------------
  // Condition
  // ---------------------------------------------------------------------
  assign equal = rs1_data_i[`XLEN-1:0] == rs2_data_i[`XLEN-1:0];
  // Signed on the extended operands also gives bltu and bgeu
  assign less  = $signed(rs1_data_i) < $signed(rs2_data_i);
  assign jump  = cmd_i[JAL] | cmd_i[JALR];

  assign taken = (cmd_i[BEQ] & equal)
               | (cmd_i[BNE] & ~equal)
               | (cmd_i[BLT] & less)
               | (cmd_i[BGE] & ~less)
               | jump;

  // ---------------------------------------------------------------------
  // Target
  // ---------------------------------------------------------------------
  assign pc_plus4 = pc_data_i + `XLEN'd4;
  assign jalr_sum = rs1_data_i[`XLEN-1:0] + immediat_i;
  assign target   = cmd_i[JALR] ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_data_i + immediat_i;

  assign pc_nxt_o = taken ? target : pc_plus4;
  assign data_o   = (bu_en_i & jump) ? pc_plus4 : '0;

  // ---------------------------------------------------------------------
  // Prediction check
  // ---------------------------------------------------------------------
  assign pred_ok = pred_v_i & (pred_is_taken_i == taken);

  // Any instruction not correctly predicted redirects fetch
  assign branch_v_o = bu_en_i & ~pred_ok;

  assign pred_feedback_o = bu_en_i & pred_v_i;
  assign pred_success_o  = bu_en_i & pred_ok;
  assign pred_failed_o   = bu_en_i & ((pred_v_i & ~pred_ok) | (~pred_v_i & taken));

endmodule

// ==== source/lsu.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module lsu import riscv_pkg::*; (
  input  logic [`XLEN-1:0]  rs1_data_i,
  input  logic [`XLEN-1:0]  immediat_i,
  input  logic              lsu_en_i,
  input  logic [2:0]        access_size_i,
  input  logic              unsign_extension_i,
  input  logic [`XLEN-1:0]  load_data_i,
  output logic [`XLEN-1:0]  adr_o,
  output logic [`XLEN-1:0]  lsu_data_o
);

  logic             byte_sign;
  logic             half_sign;
  logic [`XLEN-1:0] ext_data;

  // Address generation
  assign adr_o = rs1_data_i + immediat_i;

  // Fill bit for the narrow loads
  assign byte_sign = ~unsign_extension_i & load_data_i[7];
  assign half_sign = ~unsign_extension_i & load_data_i[15];

  // ---------------------------------------------------------------------
  // Load data extension
  // ---------------------------------------------------------------------
  always_comb begin
    ext_data = '0;
    if (access_size_i[SZ_B]) begin
      ext_data = {{(`XLEN-8){byte_sign}}, load_data_i[7:0]};
    end else if (access_size_i[SZ_H]) begin
      ext_data = {{(`XLEN-16){half_sign}}, load_data_i[15:0]};
    end else if (access_size_i[SZ_W]) begin
      ext_data = load_data_i;
    end
  end

  assign lsu_data_o = lsu_en_i ? ext_data : '0;

endmodule

// ==== source/exe.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module exe import riscv_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  // Decode
  input  dec_exe_t          dec_i,
  input  logic              pred_v_i,
  input  logic              pred_is_taken_i,
  // Memory side
  input  logic [`XLEN-1:0]  load_data_i,
  output mem_req_t          mem_req_o,
  // Forwarding and writeback
  output wbk_t              exe_fwd_o,
  output wbk_t              wbk_o,
  // Redirect and fetch feedback
  output logic              flush_v_q_o,
  output logic [`XLEN-1:0]  pc_data_q_o,
  output pred_fb_t          pred_fb_q_o
);

  // Unit enables and results
  logic             cancel;
  logic             alu_en;
  logic             shifter_en;
  logic             bu_en;
  logic             lsu_en;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] shifter_res;
  logic [`XLEN-1:0] bu_res;
  logic [`XLEN-1:0] lsu_res;
  logic [`XLEN-1:0] lsu_adr;
  // Branch unit
  logic             branch_v;
  logic [`XLEN-1:0] bu_pc_nxt;
  logic             bu_pred_feedback;
  logic             bu_pred_success;
  logic             bu_pred_failed;
  // Result merge
  logic             rd_v_nxt;
  logic [`XLEN-1:0] res_data_nxt;
  // Registered state
  wbk_t             wbk_q;
  logic             flush_v_q;
  logic             flush_v_dly1_q;
  logic [`XLEN-1:0] pc_data_q;
  logic [`XLEN-1:0] fb_pc_q;
  logic             branch_instr_q;
  logic             pred_feedback_q;
  logic             pred_success_q;
  logic             pred_failed_q;

  // ---------------------------------------------------------------------
  // Units
  // ---------------------------------------------------------------------
  alu u_alu (
    .rs1_data_i (dec_i.rs1_data),
    .rs2_data_i (dec_i.rs2_data),
    .alu_en_i   (alu_en),
    .cmd_i      (dec_i.operation),
    .data_o     (alu_res)
  );

  shifter u_shifter (
    .rs1_data_i   (dec_i.rs1_data[`XLEN-1:0]),
    .rs2_data_i   (dec_i.rs2_data[`XLEN-1:0]),
    .shifter_en_i (shifter_en),
    .cmd_i        (dec_i.operation),
    .data_o       (shifter_res)
  );

  bu u_bu (
    .rs1_data_i      (dec_i.rs1_data),
    .rs2_data_i      (dec_i.rs2_data),
    .immediat_i      (dec_i.immediat),
    .pc_data_i       (dec_i.pc),
    .bu_en_i         (bu_en),
    .cmd_i           (dec_i.operation),
    .pred_v_i        (pred_v_i),
    .pred_is_taken_i (pred_is_taken_i),
    .branch_v_o      (branch_v),
    .pc_nxt_o        (bu_pc_nxt),
    .data_o          (bu_res),
    .pred_feedback_o (bu_pred_feedback),
    .pred_success_o  (bu_pred_success),
    .pred_failed_o   (bu_pred_failed)
  );

  lsu u_lsu (
    .rs1_data_i         (dec_i.rs1_data[`XLEN-1:0]),
    .immediat_i         (dec_i.immediat),
    .lsu_en_i           (lsu_en),
    .access_size_i      (dec_i.access_size),
    .unsign_extension_i (dec_i.unsign_extension),
    .load_data_i        (load_data_i),
    .adr_o              (lsu_adr),
    .lsu_data_o         (lsu_res)
  );

  // ---------------------------------------------------------------------
  // Enables and memory request
  // ---------------------------------------------------------------------
  // Two instructions behind a redirect are already in flight, kill them
  assign cancel     = flush_v_q | flush_v_dly1_q;
  assign alu_en     = dec_i.unit[ALU] & ~cancel;
  assign shifter_en = dec_i.unit[SFT] & ~cancel;
  assign bu_en      = dec_i.unit[BU]  & ~cancel;
  assign lsu_en     = dec_i.unit[LSU] & ~cancel;

  assign mem_req_o.adr_v       = lsu_en;
  assign mem_req_o.adr         = lsu_adr;
  assign mem_req_o.is_store    = lsu_en & dec_i.operation[ST];
  assign mem_req_o.store_data  = {`XLEN{lsu_en}} & dec_i.rs2_data[`XLEN-1:0];
  assign mem_req_o.access_size = dec_i.access_size;

  // ---------------------------------------------------------------------
  // Result merge
  // ---------------------------------------------------------------------
  assign rd_v_nxt = dec_i.rd_v & ~cancel;

  // Stores give no result
  assign res_data_nxt = alu_res
                      | shifter_res
                      | bu_res
                      | ({`XLEN{~dec_i.operation[ST]}} & lsu_res);

  assign exe_fwd_o.v    = rd_v_nxt;
  assign exe_fwd_o.adr  = dec_i.rd_adr;
  assign exe_fwd_o.data = res_data_nxt;

  // ---------------------------------------------------------------------
  // Output registers
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wbk_q           <= '0;
      flush_v_q       <= 1'b0;
      flush_v_dly1_q  <= 1'b0;
      branch_instr_q  <= 1'b0;
      pred_feedback_q <= 1'b0;
      pred_success_q  <= 1'b0;
      pred_failed_q   <= 1'b0;
    end else begin
      wbk_q           <= exe_fwd_o;
      flush_v_q       <= branch_v;
      flush_v_dly1_q  <= flush_v_q;
      branch_instr_q  <= bu_en;
      pred_feedback_q <= bu_pred_feedback;
      pred_success_q  <= bu_pred_success;
      pred_failed_q   <= bu_pred_failed;
    end
  end

  // Redirect target and branch pc
  always_ff @(posedge clk) begin
    pc_data_q <= bu_pc_nxt;
    fb_pc_q   <= dec_i.pc;
  end

  assign wbk_o       = wbk_q;
  assign flush_v_q_o = flush_v_q;
  assign pc_data_q_o = pc_data_q;

  assign pred_fb_q_o.pc           = fb_pc_q;
  assign pred_fb_q_o.branch_instr = branch_instr_q;
  assign pred_fb_q_o.feedback     = pred_feedback_q;
  assign pred_fb_q_o.success      = pred_success_q;
  assign pred_fb_q_o.failed       = pred_failed_q;

endmodule

// ==== testbench/exe_checker.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module exe_checker import riscv_pkg::*; (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             done_i,
  input  dec_exe_t         dec_i,
  input  logic             pred_v_i,
  input  logic             pred_is_taken_i,
  input  logic [`XLEN-1:0] load_data_i,
  input  mem_req_t         mem_req_i,
  input  wbk_t             exe_fwd_i,
  input  wbk_t             wbk_i,
  input  logic             flush_v_q_i,
  input  logic [`XLEN-1:0] pc_data_q_i,
  input  pred_fb_t         pred_fb_q_i,
  output int               err_cnt_o,
  output logic             reported_o
);

  localparam int NB_TEST = 6;

  int               checks [NB_TEST] = '{default: 0};
  int               fails  [NB_TEST] = '{default: 0};
  int               total_checks;
  int               total_fails;
  // Model of the flush delay line
  logic             m_flush_q;
  logic             m_flush_dly_q;
  // Current instruction
  logic             cancel;
  logic             en_arith;
  logic             en_bu;
  logic             en_lsu;
  logic             taken;
  logic             pred_ok;
  logic             redirect;
  logic [`XLEN-1:0] exp_data;
  int               cat;
  // Expected registered outputs, one cycle later
  int               prev_cat;
  wbk_t             exp_wbk;
  logic             exp_flush;
  logic [`XLEN-1:0] exp_pc;
  pred_fb_t         exp_fb;

  function automatic string test_name(int t);
    case (t)
      0: return "alu and shifter";
      1: return "loads and stores";
      2: return "branches and jumps";
      3: return "cancellation";
      4: return "prediction feedback";
      default: return "reset";
    endcase
  endfunction

  // Signed compare of the qualified 33-bit operands
  function automatic logic less_ext(logic [`XLEN:0] a, logic [`XLEN:0] b);
    if (a[`XLEN] != b[`XLEN]) begin
      return a[`XLEN];
    end
    return a[`XLEN-1:0] < b[`XLEN-1:0];
  endfunction

  function automatic logic [`XLEN-1:0] arith_model(dec_exe_t d);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [4:0]       sh;
    a  = d.rs1_data[`XLEN-1:0];
    b  = d.rs2_data[`XLEN-1:0];
    sh = b[4:0];
    if (d.operation[ADD]) return a + b;
    if (d.operation[SUB]) return a - b;
    if (d.operation[AND]) return a & b;
    if (d.operation[OR]) return a | b;
    if (d.operation[XOR]) return a ^ b;
    if (d.operation[SLT] || d.operation[SLTU]) begin
      return {{(`XLEN-1){1'b0}}, less_ext(d.rs1_data, d.rs2_data)};
    end
    if (d.operation[SLL]) return a << sh;
    if (d.operation[SRL]) return a >> sh;
    // Sign bits refill the vacated top
    if (d.operation[SRA]) return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
    return '0;
  endfunction

  function automatic logic bu_taken(dec_exe_t d);
    logic eq;
    logic lt;
    eq = d.rs1_data[`XLEN-1:0] == d.rs2_data[`XLEN-1:0];
    lt = less_ext(d.rs1_data, d.rs2_data);
    return (d.operation[BEQ] && eq) || (d.operation[BNE] && !eq)
        || (d.operation[BLT] && lt) || (d.operation[BGE] && !lt)
        || d.operation[JAL] || d.operation[JALR];
  endfunction

  function automatic logic [`XLEN-1:0] bu_target(dec_exe_t d);
    logic [`XLEN-1:0] sum;
    if (d.operation[JALR]) begin
      sum = d.rs1_data[`XLEN-1:0] + d.immediat;
      return sum & ~`XLEN'd1;
    end
    return d.pc + d.immediat;
  endfunction

  function automatic logic [`XLEN-1:0] load_model(dec_exe_t d, logic [`XLEN-1:0] ld);
    logic fill;
    if (d.access_size[SZ_B]) begin
      fill = !d.unsign_extension && ld[7];
      return {{(`XLEN-8){fill}}, ld[7:0]};
    end
    if (d.access_size[SZ_H]) begin
      fill = !d.unsign_extension && ld[15];
      return {{(`XLEN-16){fill}}, ld[15:0]};
    end
    return ld;
  endfunction

  task automatic check_word(int test, string name, logic [`XLEN-1:0] exp,
                            logic [`XLEN-1:0] act);
    checks[test]++;
    if (exp !== act) begin
      fails[test]++;
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(int test, string name, logic exp, logic act);
    checks[test]++;
    if (exp !== act) begin
      fails[test]++;
      $display("FAIL t=%0t %s expected=%b actual=%b", $time, name, exp, act);
    end
  endtask

  // ---------------------------------------------------------------------
  // Registered outputs against last cycle's model
  // ---------------------------------------------------------------------
  task automatic check_registered();
    int fb_cat;
    fb_cat = (prev_cat == 2) ? 4 : prev_cat;
    check_bit(prev_cat, "wbk_o.v", exp_wbk.v, wbk_i.v);
    if (exp_wbk.v) begin
      check_word(prev_cat, "wbk_o.adr", {27'd0, exp_wbk.adr}, {27'd0, wbk_i.adr});
      check_word(prev_cat, "wbk_o.data", exp_wbk.data, wbk_i.data);
    end
    check_bit(prev_cat, "flush_v_q_o", exp_flush, flush_v_q_i);
    if (exp_flush) begin
      check_word(prev_cat, "pc_data_q_o", exp_pc, pc_data_q_i);
    end
    check_bit(fb_cat, "pred_fb.branch_instr", exp_fb.branch_instr, pred_fb_q_i.branch_instr);
    check_bit(fb_cat, "pred_fb.feedback", exp_fb.feedback, pred_fb_q_i.feedback);
    check_bit(fb_cat, "pred_fb.success", exp_fb.success, pred_fb_q_i.success);
    check_bit(fb_cat, "pred_fb.failed", exp_fb.failed, pred_fb_q_i.failed);
    if (exp_fb.branch_instr) begin
      check_word(fb_cat, "pred_fb.pc", exp_fb.pc, pred_fb_q_i.pc);
    end
  endtask

  // ---------------------------------------------------------------------
  // Current instruction, combinational outputs
  // ---------------------------------------------------------------------
  task automatic check_instruction();
    cancel   = m_flush_q | m_flush_dly_q;
    en_arith = !cancel && (dec_i.unit[ALU] || dec_i.unit[SFT]);
    en_bu    = !cancel && dec_i.unit[BU];
    en_lsu   = !cancel && dec_i.unit[LSU];
    cat      = cancel ? 3 : (dec_i.unit[BU] ? 2 : (dec_i.unit[LSU] ? 1 : 0));
    taken    = bu_taken(dec_i);
    pred_ok  = pred_v_i && (pred_is_taken_i == taken);
    redirect = en_bu && !pred_ok;

    exp_data = '0;
    if (en_arith) begin
      exp_data = arith_model(dec_i);
    end
    if (en_bu && (dec_i.operation[JAL] || dec_i.operation[JALR])) begin
      exp_data = dec_i.pc + `XLEN'd4;
    end
    if (en_lsu && dec_i.operation[LD]) begin
      exp_data = load_model(dec_i, load_data_i);
    end

    check_bit(cat, "mem_req_o.adr_v", en_lsu, mem_req_i.adr_v);
    check_bit(cat, "mem_req_o.is_store", en_lsu && dec_i.operation[ST], mem_req_i.is_store);
    check_word(cat, "mem_req_o.store_data",
               en_lsu ? dec_i.rs2_data[`XLEN-1:0] : '0, mem_req_i.store_data);
    if (en_lsu) begin
      check_word(cat, "mem_req_o.adr", dec_i.rs1_data[`XLEN-1:0] + dec_i.immediat,
                 mem_req_i.adr);
      check_word(cat, "mem_req_o.access_size", {29'd0, dec_i.access_size},
                 {29'd0, mem_req_i.access_size});
    end
    check_bit(cat, "exe_fwd_o.v", dec_i.rd_v && !cancel, exe_fwd_i.v);
    if (dec_i.rd_v && !cancel) begin
      check_word(cat, "exe_fwd_o.adr", {27'd0, dec_i.rd_adr}, {27'd0, exe_fwd_i.adr});
    end
    check_word(cat, "exe_fwd_o.data", exp_data, exe_fwd_i.data);

    exp_wbk.v           = dec_i.rd_v && !cancel;
    exp_wbk.adr         = dec_i.rd_adr;
    exp_wbk.data        = exp_data;
    exp_flush           = redirect;
    exp_pc              = taken ? bu_target(dec_i) : dec_i.pc + `XLEN'd4;
    exp_fb.pc           = dec_i.pc;
    exp_fb.branch_instr = en_bu;
    exp_fb.feedback     = en_bu && pred_v_i;
    exp_fb.success      = en_bu && pred_ok;
    exp_fb.failed       = en_bu && (pred_v_i ? (pred_is_taken_i != taken) : taken);
    prev_cat            = cat;
    m_flush_dly_q       = m_flush_q;
    m_flush_q           = redirect;
  endtask

  task automatic print_report();
    total_checks = 0;
    total_fails  = 0;
    for (int t = 0; t < NB_TEST; t++) begin
      $display("Test %0d, %s: %0d checks, %0d errors", t + 1, test_name(t), checks[t],
               fails[t]);
      total_checks += checks[t];
      total_fails  += fails[t];
    end
    $display("Totals: %0d checks, %0d errors", total_checks, total_fails);
    err_cnt_o = total_fails;
  endtask

  // Sampled mid-cycle, away from both edges of the stimulus
  always @(negedge clk) begin
    if (!reset_n) begin
      check_bit(5, "wbk_o.v", 1'b0, wbk_i.v);
      check_word(5, "wbk_o.data", '0, wbk_i.data);
      check_bit(5, "flush_v_q_o", 1'b0, flush_v_q_i);
      check_bit(5, "pred_fb.feedback", 1'b0, pred_fb_q_i.feedback);
      check_bit(5, "pred_fb.success", 1'b0, pred_fb_q_i.success);
      check_bit(5, "pred_fb.failed", 1'b0, pred_fb_q_i.failed);
      check_bit(5, "pred_fb.branch_instr", 1'b0, pred_fb_q_i.branch_instr);
      m_flush_q     = 1'b0;
      m_flush_dly_q = 1'b0;
      exp_wbk       = '0;
      exp_flush     = 1'b0;
      exp_pc        = '0;
      exp_fb        = '0;
      prev_cat      = 5;
      reported_o    = 1'b0;
    end else begin
      check_registered();
      check_instruction();
      if (done_i && !reported_o) begin
        print_report();
        reported_o = 1'b1;
      end
    end
  end

endmodule

// ==== testbench/tb_exe.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module tb_exe import riscv_pkg::*; ();

  localparam int N_INSTR   = 400;
  localparam int RESET_CYC = 16;
  // Run length after reset plus margin
  localparam int MAX_CYC   = N_INSTR + 20;

  logic             clk;
  logic             reset_n;
  dec_exe_t         dec;
  logic             pred_v;
  logic             pred_is_taken;
  logic [`XLEN-1:0] load_data;
  mem_req_t         mem_req;
  wbk_t             exe_fwd;
  wbk_t             wbk;
  logic             flush_v_q;
  logic [`XLEN-1:0] pc_data_q;
  pred_fb_t         pred_fb_q;
  logic             done;
  logic             reported;
  int               err_cnt;
  int               seed;
  int               cycle_cnt = 0;

  exe i_dut (
    .clk             (clk),
    .reset_n         (reset_n),
    .dec_i           (dec),
    .pred_v_i        (pred_v),
    .pred_is_taken_i (pred_is_taken),
    .load_data_i     (load_data),
    .mem_req_o       (mem_req),
    .exe_fwd_o       (exe_fwd),
    .wbk_o           (wbk),
    .flush_v_q_o     (flush_v_q),
    .pc_data_q_o     (pc_data_q),
    .pred_fb_q_o     (pred_fb_q)
  );

  exe_checker i_checker (
    .clk             (clk),
    .reset_n         (reset_n),
    .done_i          (done),
    .dec_i           (dec),
    .pred_v_i        (pred_v),
    .pred_is_taken_i (pred_is_taken),
    .load_data_i     (load_data),
    .mem_req_i       (mem_req),
    .exe_fwd_i       (exe_fwd),
    .wbk_i           (wbk),
    .flush_v_q_i     (flush_v_q),
    .pc_data_q_i     (pc_data_q),
    .pred_fb_q_i     (pred_fb_q),
    .err_cnt_o       (err_cnt),
    .reported_o      (reported)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [`XLEN-1:0] rand32();
    rand32 = $random(seed);
  endfunction

  // Memory stub returns a fresh word every cycle
  task automatic drive_idle();
    dec           = '0;
    pred_v        = 1'b0;
    pred_is_taken = 1'b0;
    load_data     = rand32();
  endtask

  // ---------------------------------------------------------------------
  // Random instruction, operands qualified the way decode does it
  // ---------------------------------------------------------------------
  task automatic drive_random_instr();
    logic [`XLEN-1:0] r;
    logic [`XLEN-1:0] f;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic             sgn;
    int               op;
    r = rand32();
    f = rand32();
    a = rand32();
    b = r[24] ? a : rand32();
    dec = '0;
    sgn = 1'b1;
    case (int'(r[2:0]))
      0, 1, 2: begin
        dec.unit[ALU] = 1'b1;
        op = ADD + int'(r[7:0]) % 7;
        sgn = (op != SLTU);
      end
      3, 4: begin
        dec.unit[SFT] = 1'b1;
        op = SLL + int'(r[7:0]) % 3;
      end
      5: begin
        dec.unit[BU] = 1'b1;
        op = BEQ + int'(r[9:3]) % 6;
        // Unsigned flavour of blt and bge
        if (op == BLT || op == BGE) begin
          sgn = r[10];
        end
      end
      default: begin
        dec.unit[LSU] = 1'b1;
        op = r[8] ? ST : LD;
      end
    endcase
    dec.operation        = {{(NB_OPERATION-1){1'b0}}, 1'b1} << op;
    dec.pc               = {f[31:2], 2'b00};
    dec.rs1_data         = {sgn & a[`XLEN-1], a};
    dec.rs2_data         = {sgn & b[`XLEN-1], b};
    dec.immediat         = {{(`XLEN-12){r[31]}}, r[31:20]};
    dec.access_size      = r[12] ? 3'b100 : (r[11] ? 3'b010 : 3'b001);
    dec.unsign_extension = r[13];
    dec.rd_adr           = r[18:14];
    dec.rd_v             = r[19];
    pred_v               = f[0];
    pred_is_taken        = f[1];
    load_data            = rand32();
  endtask

  always @(posedge clk) begin
    if (reset_n) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYC) begin
        $display("Timeout, run still going after %0d cycles", MAX_CYC);
        $display("SIMULATION FAILED");
        $finish;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    seed    = 66;
    reset_n = 1'b0;
    done    = 1'b0;
    drive_idle();
    repeat (RESET_CYC) @(posedge clk);
    #2;
    reset_n = 1'b1;
    for (int i = 0; i < N_INSTR; i++) begin
      drive_random_instr();
      @(posedge clk);
      #2;
    end
    // Let the last results leave the registers
    drive_idle();
    @(posedge clk);
    #2;
    drive_idle();
    done = 1'b1;
    wait (reported);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/riscv_pkg.sv
source/alu.sv
source/shifter.sv
source/bu.sv
source/lsu.sv
source/exe.sv
testbench/exe_checker.sv
testbench/tb_exe.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module tb_exe

sim:
	verilator --binary --timing -f filelist.f --top-module tb_exe -Mdir obj_dir -o tb_exe
	./obj_dir/tb_exe | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Failure reported, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
